// File: hdl/chan_pkg.sv
/*
 * Shared sizes, timing constants and beat structs for the channelizer shell.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package chan_pkg;

    // sample and bin geometry
    localparam int SAMPLE_W   = 16;
    localparam int BIN_W      = 11;
    localparam int MAX_BINS   = 2048;
    localparam int FFT_SIZE_W = 12;
    localparam int NFFT_W     = 5;
    localparam int NFFT_MIN   = 3;
    localparam int NFFT_MAX   = 11;
    localparam int PAYLOAD_W  = 16;

    // select mask, 32 bins per word
    localparam int SEL_WORD_W = 32;
    localparam int SEL_WORDS  = 64;
    localparam int SEL_PTR_W  = 6;

    // internal reset hold lengths
    localparam int HOLD_W          = 5;
    localparam int HOLD_CYCLES     = 8;
    localparam int POR_HOLD_CYCLES = 16;

    localparam logic [NFFT_W-1:0] NFFT_DEFAULT = 5'd3;

    // real in the upper half, imaginary in the lower half
    typedef struct packed {
        logic [SAMPLE_W-1:0] re;
        logic [SAMPLE_W-1:0] im;
    } sample_t;

    typedef struct packed {
        sample_t          sample;
        logic [BIN_W-1:0] bin;
        logic             frame_last;
    } idx_beat_t;

    typedef struct packed {
        sample_t          sample;
        logic [BIN_W-1:0] bin;
        logic             eob;
    } chan_beat_t;

endpackage

`default_nettype wire

// File: hdl/hold_timer.sv
/*
 * Down-counter timing the internal block reset hold.
 * Reloads on load_i and reports done once it has counted out.
 */
`timescale 1ns/1ps
`default_nettype none

module hold_timer import chan_pkg::*; (
    input  wire              clk,
    input  wire              sync_reset,
    input  wire              load_i,
    input  wire [HOLD_W-1:0] len_i,
    output logic             done_o
);

    logic [HOLD_W-1:0] cnt_q;

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= len_i;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign done_o = (cnt_q == '0);

    a_load_restarts: assert property (@(posedge clk) disable iff (sync_reset)
        load_i && (len_i != '0) |=> !done_o);

endmodule

`default_nettype wire

// File: hdl/chan_config_fsm.sv
/*
 * Configuration sequencer. Holds the data path in block reset after power-up
 * or after a change of FFT size or payload length, then issues one FFT
 * configuration strobe carrying the log2 size.
 */
`timescale 1ns/1ps
`default_nettype none

module chan_config_fsm import chan_pkg::*; (
    input  wire                   clk,
    input  wire                   sync_reset,
    input  wire  [FFT_SIZE_W-1:0] fft_size_i,
    input  wire  [PAYLOAD_W-1:0]  payload_length_i,
    input  wire                   hold_done_i,
    output logic                  hold_load_o,
    output logic [HOLD_W-1:0]     hold_len_o,
    output logic                  block_reset_o,
    output logic [FFT_SIZE_W-1:0] fft_size_o,
    output logic [PAYLOAD_W-1:0]  payload_length_o,
    output logic                  cfg_valid_o,
    output logic [NFFT_W-1:0]     cfg_nfft_o
);

    typedef enum logic [1:0] {S_HOLD, S_CONFIG, S_RUN} state_t;

    state_t                state_q;
    logic                  por_q;
    logic [FFT_SIZE_W-1:0] fft_size_q;
    logic [NFFT_W-1:0]     nfft;
    logic                  change;

    // supported powers of two map to log2, anything else to the default
    function automatic logic [NFFT_W-1:0] nfft_of(input logic [FFT_SIZE_W-1:0] size);
        logic [NFFT_W-1:0] code;
        code = NFFT_DEFAULT;
        for (int k = NFFT_MIN; k <= NFFT_MAX; k++) begin
            if (size == (FFT_SIZE_W'(1) << k)) begin
                code = NFFT_W'(k);
            end
        end
        return code;
    endfunction

    // a zero size is ignored
    assign change = ((fft_size_i != '0) && (fft_size_i != fft_size_q)) ||
                    (payload_length_i != payload_length_o);

    assign hold_load_o = por_q | change;
    assign hold_len_o  = por_q ? HOLD_W'(POR_HOLD_CYCLES) : HOLD_W'(HOLD_CYCLES);
    assign nfft        = nfft_of(fft_size_q);
    assign fft_size_o  = FFT_SIZE_W'(1) << nfft;

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            state_q          <= S_HOLD;
            por_q            <= 1'b1;
            block_reset_o    <= 1'b1;
            cfg_valid_o      <= 1'b0;
            cfg_nfft_o       <= NFFT_DEFAULT;
            fft_size_q       <= FFT_SIZE_W'(1) << NFFT_DEFAULT;
            payload_length_o <= '0;
        end else begin
            por_q       <= 1'b0;
            cfg_valid_o <= 1'b0;
            if (hold_load_o) begin
                state_q          <= S_HOLD;
                block_reset_o    <= 1'b1;
                payload_length_o <= payload_length_i;
                if (fft_size_i != '0) begin
                    fft_size_q <= fft_size_i;
                end
            end else begin
                case (state_q)
                    S_HOLD: begin
                        if (hold_done_i) begin
                            block_reset_o <= 1'b0;
                            state_q       <= S_CONFIG;
                        end
                    end
                    S_CONFIG: begin
                        cfg_valid_o <= 1'b1;
                        cfg_nfft_o  <= nfft;
                        state_q     <= S_RUN;
                    end
                    default: begin
                        state_q <= S_RUN;
                    end
                endcase
            end
        end
    end

    a_cfg_outside_reset: assert property (@(posedge clk) disable iff (sync_reset)
        !(cfg_valid_o && block_reset_o));

endmodule

`default_nettype wire

// File: hdl/axis_reg_slice.sv
/*
 * Valid/ready register slice with a skid entry, full throughput.
 * The payload type is set per instance through payload_t.
 */
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           sync_reset,
    input  wire           s_valid_i,
    input  wire payload_t s_data_i,
    input  wire           m_ready_i,
    output logic          s_ready_o,
    output logic          m_valid_o,
    output payload_t      m_data_o
);

    payload_t skid_data_q;
    logic     skid_valid_q;
    logic     take_in;
    logic     out_free;
    logic     skid_next;

    assign take_in  = s_valid_i & s_ready_o;
    assign out_free = m_ready_i | ~m_valid_o;

    // skid fills only when the output register is stalled
    always_comb begin
        skid_next = skid_valid_q;
        if (out_free) begin
            skid_next = 1'b0;
        end else if (take_in) begin
            skid_next = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            m_valid_o    <= 1'b0;
            skid_valid_q <= 1'b0;
            s_ready_o    <= 1'b0;
        end else begin
            if (out_free) begin
                m_valid_o <= skid_valid_q | take_in;
            end
            skid_valid_q <= skid_next;
            s_ready_o    <= ~skid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            m_data_o <= skid_valid_q ? skid_data_q : s_data_i;
        end
        if (take_in && !out_free) begin
            skid_data_q <= s_data_i;
        end
    end

    a_hold_when_stalled: assert property (@(posedge clk) disable iff (sync_reset)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o));

endmodule

`default_nettype wire

// File: hdl/bin_indexer.sv
/*
 * Bin commutator. Each accepted sample is registered together with its bin
 * index, which wraps at fft_size, and a flag on the last bin of the frame.
 */
`timescale 1ns/1ps
`default_nettype none

module bin_indexer import chan_pkg::*; (
    input  wire                  clk,
    input  wire                  sync_reset,
    input  wire [FFT_SIZE_W-1:0] fft_size_i,
    input  wire                  s_valid_i,
    input  wire sample_t         s_data_i,
    input  wire                  m_ready_i,
    output logic                 s_ready_o,
    output logic                 m_valid_o,
    output idx_beat_t            m_data_o
);

    logic [BIN_W-1:0] bin_q;
    logic [BIN_W-1:0] last_bin;
    logic             at_last;
    logic             take;

    assign last_bin  = BIN_W'(fft_size_i - 1'b1);
    assign at_last   = (bin_q == last_bin);
    assign s_ready_o = m_ready_i | ~m_valid_o;
    assign take      = s_valid_i & s_ready_o;

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            m_valid_o <= 1'b0;
            bin_q     <= '0;
        end else begin
            if (s_ready_o) begin
                m_valid_o <= s_valid_i;
            end
            if (take) begin
                bin_q <= at_last ? '0 : bin_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_data_o <= '{sample: s_data_i, bin: bin_q, frame_last: at_last};
        end
    end

endmodule

`default_nettype wire

// File: hdl/bin_downselect.sv
/*
 * Bin down-selection. A 2048-bit mask, loaded word by word over the select
 * stream, decides which bins pass. Every input beat is consumed; the last
 * passing bin of each frame carries eob, found by scanning the mask ahead.
 */
`timescale 1ns/1ps
`default_nettype none

module bin_downselect import chan_pkg::*; (
    input  wire                  clk,
    input  wire                  sync_reset,
    input  wire                  block_reset_i,
    input  wire [FFT_SIZE_W-1:0] fft_size_i,
    input  wire                  s_valid_i,
    input  wire idx_beat_t       s_data_i,
    input  wire                  sel_valid_i,
    input  wire [SEL_WORD_W-1:0] sel_data_i,
    input  wire                  sel_last_i,
    input  wire                  m_ready_i,
    output logic                 s_ready_o,
    output logic                 sel_ready_o,
    output logic                 m_valid_o,
    output chan_beat_t           m_data_o
);

    logic [SEL_WORDS-1:0][SEL_WORD_W-1:0] mask_q;
    logic [SEL_PTR_W-1:0]                 wr_ptr_q;
    logic [MAX_BINS-1:0]                  mask_flat;
    logic [MAX_BINS-1:0]                  after_bin;
    logic [MAX_BINS-1:0]                  in_frame;
    logic [BIN_W-1:0]                     last_bin;
    logic                                 sel_hit;
    logic                                 tail_clear;
    logic                                 take;
    logic                                 sel_wr;

    assign sel_ready_o = ~block_reset_i;
    assign sel_wr      = sel_valid_i & sel_ready_o;
    assign s_ready_o   = m_ready_i | ~m_valid_o;
    assign take        = s_valid_i & s_ready_o;

    // bit k of word w is bin 32*w + k
    assign mask_flat = mask_q;
    assign last_bin  = BIN_W'(fft_size_i - 1'b1);
    assign sel_hit   = mask_flat[s_data_i.bin];

    // selected bins still ahead of this one in the current frame
    assign after_bin  = (mask_flat >> s_data_i.bin) >> 1;
    assign in_frame   = ~({MAX_BINS{1'b1}} << (last_bin - s_data_i.bin));
    assign tail_clear = s_data_i.frame_last | ~|(after_bin & in_frame);

    // mask loader, contents kept across block reset
    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            mask_q   <= '1;
            wr_ptr_q <= '0;
        end else if (block_reset_i) begin
            wr_ptr_q <= '0;
        end else if (sel_wr) begin
            mask_q[wr_ptr_q] <= sel_data_i;
            wr_ptr_q         <= sel_last_i ? '0 : wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            m_valid_o <= 1'b0;
        end else if (block_reset_i) begin
            m_valid_o <= 1'b0;
        end else if (s_ready_o) begin
            m_valid_o <= take & sel_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_data_o <= '{sample: s_data_i.sample, bin: s_data_i.bin, eob: tail_clear};
        end
    end

    // a freshly loaded output beat carries a bin whose mask bit is set
    a_only_selected: assert property (@(posedge clk)
        disable iff (sync_reset || block_reset_i)
        m_valid_o && $past(take) && !$past(sel_wr) |-> mask_flat[m_data_o.bin]);

endmodule

`default_nettype wire

// File: hdl/frame_counter.sv
/*
 * Output framing. Counts transferred beats and flags tlast every
 * payload_length beats; a length of zero frames every beat.
 */
`timescale 1ns/1ps
`default_nettype none

module frame_counter import chan_pkg::*; (
    input  wire                 clk,
    input  wire                 sync_reset,
    input  wire [PAYLOAD_W-1:0] payload_length_i,
    input  wire                 s_valid_i,
    input  wire chan_beat_t     s_data_i,
    input  wire                 m_ready_i,
    output logic                s_ready_o,
    output logic                m_valid_o,
    output chan_beat_t          m_data_o,
    output logic                m_last_o
);

    logic [PAYLOAD_W-1:0] cnt_q;
    logic [PAYLOAD_W-1:0] limit;
    logic                 at_limit;

    assign limit    = (payload_length_i == '0) ? '0 : payload_length_i - 1'b1;
    assign at_limit = (cnt_q == limit);

    assign s_ready_o = m_ready_i;
    assign m_valid_o = s_valid_i;
    assign m_data_o  = s_data_i;
    assign m_last_o  = s_valid_i & at_limit;

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            cnt_q <= '0;
        end else if (m_valid_o && m_ready_i) begin
            cnt_q <= at_limit ? '0 : cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/chan_top.sv
/*
 * Control and framing shell of the M/2 polyphase channelizer bank.
 * Samples are indexed by bin, down-selected by mask and framed into
 * payloads; the FFT configuration strobe is exported on cfg_valid_o.
 */
`timescale 1ns/1ps
`default_nettype none

module chan_top import chan_pkg::*; (
    input  wire                  clk,
    input  wire                  sync_reset,
    input  wire                  s_valid_i,
    input  wire sample_t         s_data_i,
    output logic                 s_ready_o,
    input  wire                  sel_valid_i,
    input  wire [SEL_WORD_W-1:0] sel_data_i,
    input  wire                  sel_last_i,
    output logic                 sel_ready_o,
    input  wire [FFT_SIZE_W-1:0] fft_size_i,
    input  wire [PAYLOAD_W-1:0]  payload_length_i,
    output logic                 cfg_valid_o,
    output logic [NFFT_W-1:0]    cfg_nfft_o,
    output logic                 m_valid_o,
    output chan_beat_t           m_data_o,
    output logic                 m_last_o,
    input  wire                  m_ready_i
);

    logic                  block_reset;
    logic                  hold_load;
    logic [HOLD_W-1:0]     hold_len;
    logic                  hold_done;
    logic [FFT_SIZE_W-1:0] fft_size;
    logic [PAYLOAD_W-1:0]  payload_length;

    logic       in_valid, in_ready;
    sample_t    in_data;
    logic       idx_valid, idx_ready;
    idx_beat_t  idx_data;
    logic       ds_valid, ds_ready;
    chan_beat_t ds_data;
    logic       os_valid, os_ready;
    chan_beat_t os_data;

    chan_config_fsm u_config (
        .clk, .sync_reset, .fft_size_i, .payload_length_i,
        .hold_done_i(hold_done), .hold_load_o(hold_load), .hold_len_o(hold_len),
        .block_reset_o(block_reset), .fft_size_o(fft_size),
        .payload_length_o(payload_length), .cfg_valid_o, .cfg_nfft_o
    );

    hold_timer u_hold (
        .clk, .sync_reset, .load_i(hold_load), .len_i(hold_len), .done_o(hold_done)
    );

    axis_reg_slice #(.payload_t(sample_t)) u_in_slice (
        .clk, .sync_reset(block_reset), .s_valid_i, .s_data_i, .s_ready_o,
        .m_valid_o(in_valid), .m_data_o(in_data), .m_ready_i(in_ready)
    );

    bin_indexer u_indexer (
        .clk, .sync_reset(block_reset), .fft_size_i(fft_size),
        .s_valid_i(in_valid), .s_data_i(in_data), .s_ready_o(in_ready),
        .m_valid_o(idx_valid), .m_data_o(idx_data), .m_ready_i(idx_ready)
    );

    bin_downselect u_downselect (
        .clk, .sync_reset, .block_reset_i(block_reset), .fft_size_i(fft_size),
        .s_valid_i(idx_valid), .s_data_i(idx_data), .s_ready_o(idx_ready),
        .sel_valid_i, .sel_data_i, .sel_last_i, .sel_ready_o,
        .m_valid_o(ds_valid), .m_data_o(ds_data), .m_ready_i(ds_ready)
    );

    axis_reg_slice #(.payload_t(chan_beat_t)) u_out_slice (
        .clk, .sync_reset(block_reset), .s_valid_i(ds_valid), .s_data_i(ds_data),
        .s_ready_o(ds_ready), .m_valid_o(os_valid), .m_data_o(os_data),
        .m_ready_i(os_ready)
    );

    frame_counter u_framer (
        .clk, .sync_reset(block_reset), .payload_length_i(payload_length),
        .s_valid_i(os_valid), .s_data_i(os_data), .s_ready_o(os_ready),
        .m_valid_o, .m_data_o, .m_last_o, .m_ready_i
    );

endmodule

`default_nettype wire

// File: sim/chan_tb.sv
/*
 * Testbench for the channelizer shell. A model queue predicts each output
 * beat from the accepted inputs and the select mask. Concurrent assertions
 * compare the DUT against it. Build through the file list at the project root.
 */
`timescale 1ns/1ps
`default_nettype none

module chan_tb import chan_pkg::*; ();

    localparam int SEED        = 32'h4b69_4587;
    localparam int TOTAL_BEATS = 1200;
    // random valid and ready cost a few cycles per beat, plus five holds
    localparam int MAX_CYCLES  = 16 * TOTAL_BEATS + 800;

    logic                  clk = 1'b0;
    logic                  sync_reset;
    logic                  s_valid_i;
    sample_t               s_data_i;
    logic                  s_ready_o;
    logic                  sel_valid_i;
    logic [SEL_WORD_W-1:0] sel_data_i;
    logic                  sel_last_i;
    logic                  sel_ready_o;
    logic [FFT_SIZE_W-1:0] fft_size_i;
    logic [PAYLOAD_W-1:0]  payload_length_i;
    logic                  cfg_valid_o;
    logic [NFFT_W-1:0]     cfg_nfft_o;
    logic                  m_valid_o;
    chan_beat_t            m_data_o;
    logic                  m_last_o;
    logic                  m_ready_i;

    // reference model
    chan_beat_t          exp_q[$];
    chan_beat_t          new_beat;
    chan_beat_t          exp_head = '0;
    int                  exp_cnt  = 0;
    logic                last_exp = 1'b0;
    logic [MAX_BINS-1:0] mask_m   = '1;
    int                  size_m   = 8;
    int                  plen_m   = 1;
    int                  bin_cnt  = 0;
    int                  out_cnt  = 0;
    int                  cycles   = 0;
    logic [NFFT_W-1:0]   exp_nfft;
    int                  exp_plen;
    logic                cfg_wait;
    logic                out_fire;

    chan_top dut_i (.*);

    always #50 clk = ~clk;

    assign out_fire = m_valid_o & m_ready_i;

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
        abort_run("DUT output differs from the model");
    endtask

    // eob goes on a bin with no selected bin after it in the frame
    function automatic logic tail_of_frame(input int bin);
        logic none_after;
        none_after = 1'b1;
        for (int b = bin + 1; b < size_m; b++) begin
            if (mask_m[b]) begin
                none_after = 1'b0;
            end
        end
        return none_after;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            abort_run("timeout, the run went past its cycle limit");
        end else if (!sync_reset) begin
            // each block reset ends in a cfg pulse, so the model restarts there
            if (cfg_valid_o) begin
                size_m  = 1 << exp_nfft;
                plen_m  = (exp_plen == 0) ? 1 : exp_plen;
                bin_cnt = 0;
                out_cnt = 0;
            end
            if (s_valid_i && s_ready_o) begin
                if (mask_m[bin_cnt]) begin
                    new_beat.sample = s_data_i;
                    new_beat.bin    = BIN_W'(bin_cnt);
                    new_beat.eob    = tail_of_frame(bin_cnt);
                    exp_q.push_back(new_beat);
                end
                bin_cnt = (bin_cnt == size_m - 1) ? 0 : bin_cnt + 1;
            end
            if (out_fire) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                out_cnt = (out_cnt == plen_m - 1) ? 0 : out_cnt + 1;
            end
            exp_cnt  = exp_q.size();
            exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
            last_exp = (out_cnt == plen_m - 1);
        end
    end

    a_out_expected: assert property (@(posedge clk) disable iff (sync_reset)
        out_fire |-> exp_cnt != 0)
        else abort_run("output beat with no accepted input left to match it");
    a_out_data: assert property (@(posedge clk) disable iff (sync_reset)
        out_fire && exp_cnt != 0 |-> m_data_o == exp_head)
        else report_mismatch("m_data_o", 64'($sampled(m_data_o)), 64'($sampled(exp_head)));
    a_out_last: assert property (@(posedge clk) disable iff (sync_reset)
        out_fire |-> m_last_o == last_exp)
        else report_mismatch("m_last_o", 64'($sampled(m_last_o)), 64'($sampled(last_exp)));
    a_stall_hold: assert property (@(posedge clk) disable iff (sync_reset)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o))
        else abort_run("output beat dropped or changed while stalled");
    a_cfg_once: assert property (@(posedge clk) disable iff (sync_reset)
        cfg_valid_o |-> cfg_wait)
        else abort_run("cfg_valid_o pulsed with no configuration change pending");
    a_cfg_nfft: assert property (@(posedge clk) disable iff (sync_reset)
        cfg_valid_o |-> cfg_nfft_o == exp_nfft)
        else report_mismatch("cfg_nfft_o", 64'($sampled(cfg_nfft_o)), 64'(exp_nfft));
    a_cfg_quiet: assert property (@(posedge clk) disable iff (sync_reset)
        $past(cfg_wait) && cfg_wait && !cfg_valid_o |-> !s_ready_o && !m_valid_o)
        else abort_run("s_ready_o or m_valid_o high before the configuration pulse");
    a_sel_ready: assert property (@(posedge clk) disable iff (sync_reset)
        !cfg_wait |-> sel_ready_o)
        else abort_run("sel_ready_o low outside a configuration change");
    // block reset ends one cycle before the cfg pulse
    a_sel_hold: assert property (@(posedge clk) disable iff (sync_reset)
        cfg_valid_o |-> $past(!sel_ready_o, 2))
        else abort_run("sel_ready_o high during the block reset hold");

    task automatic wait_cfg_pulse();
        do begin
            @(posedge clk);
        end while (!cfg_valid_o);
        #1;
        cfg_wait = 1'b0;
    endtask

    task automatic configure(input int size, input int plen, input logic [NFFT_W-1:0] nfft);
        @(posedge clk);
        #1;
        exp_nfft         = nfft;
        exp_plen         = plen;
        cfg_wait         = 1'b1;
        fft_size_i       = FFT_SIZE_W'(size);
        payload_length_i = PAYLOAD_W'(plen);
        wait_cfg_pulse();
    endtask

    task automatic write_sel_word(input int idx, input logic [SEL_WORD_W-1:0] word,
                                  input logic last);
        @(posedge clk);
        #1;
        sel_valid_i = 1'b1;
        sel_data_i  = word;
        sel_last_i  = last;
        do begin
            @(posedge clk);
        end while (!sel_ready_o);
        #1;
        sel_valid_i = 1'b0;
        mask_m[idx*SEL_WORD_W +: SEL_WORD_W] = word;
    endtask

    // valid holds with its data until accepted
    task automatic stream_samples(input int n, input int valid_pct, input int ready_pct);
        int   sent;
        logic fire;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            fire = s_valid_i && s_ready_o;
            if (fire) begin
                sent++;
            end
            #1;
            m_ready_i = ($urandom_range(99) < ready_pct);
            if (fire || !s_valid_i) begin
                s_valid_i = (sent < n) && ($urandom_range(99) < valid_pct);
                s_data_i  = $urandom;
            end
        end
    endtask

    task automatic drain_pipeline();
        #1;
        m_ready_i = 1'b1;
        while (exp_cnt != 0) begin
            @(posedge clk);
        end
        // settle past the pipeline depth so a stray beat still shows up
        repeat (8) @(posedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        sync_reset       = 1'b1;
        s_valid_i        = 1'b0;
        s_data_i         = '0;
        sel_valid_i      = 1'b0;
        sel_data_i       = '0;
        sel_last_i       = 1'b0;
        fft_size_i       = FFT_SIZE_W'(8);
        payload_length_i = PAYLOAD_W'(5);
        m_ready_i        = 1'b1;
        exp_nfft         = 5'd3;
        exp_plen         = 5;
        cfg_wait         = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        sync_reset = 1'b0;
        wait_cfg_pulse();

        // default mask, 8 bins, frames of 5
        stream_samples(40, 100, 100);
        drain_pipeline();
        configure(8, 1, 5'd3);
        stream_samples(16, 100, 100);
        drain_pipeline();
        configure(256, 5, 5'd8);
        stream_samples(520, 100, 100);
        drain_pipeline();
        // unsupported size runs as 8 bins
        configure(100, 5, 5'd3);
        stream_samples(24, 100, 100);
        drain_pipeline();
        // sparse mask, highest selected bin is 58 of 64
        configure(64, 5, 5'd6);
        write_sel_word(0, 32'h8010_0206, 1'b0);
        write_sel_word(1, 32'h0400_1001, 1'b1);
        stream_samples(200, 100, 100);
        drain_pipeline();
        stream_samples(400, 60, 50);
        drain_pipeline();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/chan_pkg.sv
hdl/hold_timer.sv
hdl/chan_config_fsm.sv
hdl/axis_reg_slice.sv
hdl/bin_indexer.sv
hdl/bin_downselect.sv
hdl/frame_counter.sv
hdl/chan_top.sv
sim/chan_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the channelizer shell testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module chan_tb -f verilog.f -o chan_sim &&
./obj_dir/chan_sim | tee /dev/stderr | grep -qF "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation did not pass"; exit 1; }
